// File: src/mul_arith_pkg.sv
package mul_arith_pkg;

	// operand and result width of the integer pipeline.
	localparam int xlen = 64;

	// two extra bits turn every signedness combination into one signed multiply.
	localparam int opnd_w = xlen + 2;

	// the full product of two extended operands.
	localparam int prod_w = 2 * opnd_w;

	// one radix-4 Booth group per two multiplier bits.
	localparam int pp_num = opnd_w / 2;

	// the partial products plus the row that collects the negation bits.
	localparam int tree_rows = pp_num + 1;

endpackage

// File: src/mul_op_pkg.sv
package mul_op_pkg;

	// funct3 codes of the M extension multiplies.
	localparam logic [2:0] funct3_mul = 3'd0;
	localparam logic [2:0] funct3_mulh = 3'd1;
	localparam logic [2:0] funct3_mulhsu = 3'd2;
	localparam logic [2:0] funct3_mulhu = 3'd3;

	// which part of the 128-bit product is written back.
	typedef enum logic [1:0] {
		sel_lo = 2'd0,
		sel_hi = 2'd1,
		sel_word = 2'd2
	} res_sel_t;

endpackage

// File: src/mul_decode.sv
module mul_decode (
	input  logic                                  clk,
	input  logic                                  arst_n,
	input  logic                                  mul_valid,
	input  logic                                  flush,
	input  logic [2:0]                            funct3,
	input  logic                                  is_word,
	input  logic [mul_arith_pkg::xlen-1:0]        multiplicand,
	input  logic [mul_arith_pkg::xlen-1:0]        multiplier,
	output logic                                  dec_valid,
	output mul_op_pkg::res_sel_t                  dec_sel,
	output logic [mul_arith_pkg::opnd_w-1:0]      dec_a,
	output logic [mul_arith_pkg::opnd_w-1:0]      dec_b
);

	localparam int half = mul_arith_pkg::xlen / 2;
	localparam int ext_w = mul_arith_pkg::opnd_w - mul_arith_pkg::xlen;

	logic                           legal;
	logic                           accept;
	logic                           sign_a;
	logic                           sign_b;
	mul_op_pkg::res_sel_t           sel;
	logic [mul_arith_pkg::xlen-1:0] a_src;
	logic [mul_arith_pkg::xlen-1:0] b_src;

	// MUL and MULW take the signed path since their low bits do not depend on it.
	always_comb begin
		legal = 1'b1;
		sign_a = 1'b0;
		sign_b = 1'b0;
		sel = mul_op_pkg::sel_hi;
		case (funct3)
			mul_op_pkg::funct3_mul: begin
				sign_a = 1'b1;
				sign_b = 1'b1;
				sel = is_word ? mul_op_pkg::sel_word : mul_op_pkg::sel_lo;
			end
			mul_op_pkg::funct3_mulh: begin
				sign_a = 1'b1;
				sign_b = 1'b1;
			end
			mul_op_pkg::funct3_mulhsu: sign_a = 1'b1;
			mul_op_pkg::funct3_mulhu: sign_a = 1'b0;
			default: legal = 1'b0;
		endcase
		if (is_word && funct3 != mul_op_pkg::funct3_mul) begin
			legal = 1'b0;
		end
	end

	// the word form replaces the upper half with copies of bit 31.
	assign a_src = is_word ? {{half{multiplicand[half-1]}}, multiplicand[half-1:0]} : multiplicand;
	assign b_src = is_word ? {{half{multiplier[half-1]}}, multiplier[half-1:0]} : multiplier;

	assign accept = mul_valid && !flush && legal;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dec_valid <= 1'b0;
			dec_sel <= mul_op_pkg::sel_lo;
			dec_a <= '0;
			dec_b <= '0;
		end else begin
			dec_valid <= accept;
			if (accept) begin
				dec_sel <= sel;
				dec_a <= {{ext_w{sign_a & a_src[mul_arith_pkg::xlen-1]}}, a_src};
				dec_b <= {{ext_w{sign_b & b_src[mul_arith_pkg::xlen-1]}}, b_src};
			end
		end
	end

endmodule

// File: src/booth_pp_gen.sv
module booth_pp_gen (
	input  logic [mul_arith_pkg::opnd_w-1:0]                               a,
	input  logic [mul_arith_pkg::opnd_w-1:0]                               b,
	output logic [mul_arith_pkg::tree_rows-1:0][mul_arith_pkg::prod_w-1:0] rows
);

	localparam int pw = mul_arith_pkg::prod_w;
	localparam int ow = mul_arith_pkg::opnd_w;

	logic [pw-1:0] b_ext;
	logic [ow:0]   a_scan;

	// b is signed, so it is sign-extended over the whole product width.
	assign b_ext = {{(pw - ow){b[ow-1]}}, b};
	assign a_scan = {a, 1'b0};

	always_comb begin
		logic [2:0]    grp;
		logic [pw-1:0] mag;
		logic          neg;
		logic [pw-1:0] corr;

		corr = '0;
		for (int i = 0; i < mul_arith_pkg::pp_num; i++) begin
			grp = a_scan[2*i +: 3];
			case (grp)
				3'b001, 3'b010, 3'b101, 3'b110: mag = b_ext;
				3'b011, 3'b100: mag = b_ext << 1;
				default: mag = '0;
			endcase
			neg = grp[2] & ~(grp[1] & grp[0]);
			// -x << 2i equals (~x << 2i) plus one at bit 2i, so the low bits stay clear.
			rows[i] = (neg ? ~mag : mag) << (2 * i);
			corr[2*i] = neg;
		end
		rows[mul_arith_pkg::tree_rows-1] = corr;
	end

endmodule

// File: src/wallace_tree.sv
module wallace_tree (
	input  logic [mul_arith_pkg::tree_rows-1:0][mul_arith_pkg::prod_w-1:0] rows,
	output logic [mul_arith_pkg::prod_w-1:0]                               sum,
	output logic [mul_arith_pkg::prod_w-1:0]                               carry
);

	localparam int nr = mul_arith_pkg::tree_rows;

	// each level turns every group of three rows into two.
	function automatic int rows_at(int lvl);
		int n;
		n = nr;
		for (int i = 0; i < lvl; i++) begin
			n = 2 * (n / 3) + n % 3;
		end
		return n;
	endfunction

	function automatic int level_count();
		int n;
		int l;
		n = nr;
		l = 0;
		while (n > 2) begin
			n = 2 * (n / 3) + n % 3;
			l++;
		end
		return l;
	endfunction

	localparam int n_lvl = level_count();

	logic [nr-1:0][mul_arith_pkg::prod_w-1:0] lvl_rows [n_lvl+1];

	assign lvl_rows[0] = rows;

	for (genvar l = 0; l < n_lvl; l++) begin : g_lvl
		localparam int n_in = rows_at(l);
		localparam int n_out = rows_at(l + 1);
		localparam int n_csa = n_in / 3;

		for (genvar k = 0; k < n_csa; k++) begin : g_csa
			logic [mul_arith_pkg::prod_w-1:0] x;
			logic [mul_arith_pkg::prod_w-1:0] y;
			logic [mul_arith_pkg::prod_w-1:0] z;

			assign x = lvl_rows[l][3*k];
			assign y = lvl_rows[l][3*k+1];
			assign z = lvl_rows[l][3*k+2];
			assign lvl_rows[l+1][2*k] = x ^ y ^ z;
			assign lvl_rows[l+1][2*k+1] = ((x & y) | (x & z) | (y & z)) << 1;
		end

		for (genvar k = 3 * n_csa; k < n_in; k++) begin : g_pass
			assign lvl_rows[l+1][k-n_csa] = lvl_rows[l][k];
		end

		for (genvar k = n_out; k < nr; k++) begin : g_unused
			assign lvl_rows[l+1][k] = '0;
		end
	end

	assign sum = lvl_rows[n_lvl][0];
	assign carry = lvl_rows[n_lvl][1];

endmodule

// File: src/mul_execute.sv
module mul_execute (
	input  logic                                  clk,
	input  logic                                  arst_n,
	input  logic                                  flush,
	input  logic                                  dec_valid,
	input  mul_op_pkg::res_sel_t                  dec_sel,
	input  logic [mul_arith_pkg::opnd_w-1:0]      dec_a,
	input  logic [mul_arith_pkg::opnd_w-1:0]      dec_b,
	output logic                                  ex_valid,
	output mul_op_pkg::res_sel_t                  ex_sel,
	output logic [mul_arith_pkg::prod_w-1:0]      ex_sum,
	output logic [mul_arith_pkg::prod_w-1:0]      ex_carry
);

	logic [mul_arith_pkg::tree_rows-1:0][mul_arith_pkg::prod_w-1:0] pp_rows;
	logic [mul_arith_pkg::prod_w-1:0]                               tree_sum;
	logic [mul_arith_pkg::prod_w-1:0]                               tree_carry;

	booth_pp_gen u_booth (
		.a    (dec_a),
		.b    (dec_b),
		.rows (pp_rows)
	);

	wallace_tree u_tree (
		.rows  (pp_rows),
		.sum   (tree_sum),
		.carry (tree_carry)
	);

	// the product leaves this stage in carry-save form.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_valid <= 1'b0;
			ex_sel <= mul_op_pkg::sel_lo;
			ex_sum <= '0;
			ex_carry <= '0;
		end else begin
			ex_valid <= dec_valid && !flush;
			if (dec_valid) begin
				ex_sel <= dec_sel;
				ex_sum <= tree_sum;
				ex_carry <= tree_carry;
			end
		end
	end

endmodule

// File: src/mul_result.sv
module mul_result (
	input  logic                                  clk,
	input  logic                                  arst_n,
	input  logic                                  flush,
	input  logic                                  ex_valid,
	input  mul_op_pkg::res_sel_t                  ex_sel,
	input  logic [mul_arith_pkg::prod_w-1:0]      ex_sum,
	input  logic [mul_arith_pkg::prod_w-1:0]      ex_carry,
	output logic                                  out_valid,
	output logic [mul_arith_pkg::xlen-1:0]        result
);

	localparam int xw = mul_arith_pkg::xlen;

	logic [mul_arith_pkg::prod_w-1:0] product;
	logic [xw-1:0]                    sel_val;

	// carries out of the top bit are dropped since the product fits in the width.
	assign product = ex_sum + ex_carry;

	always_comb begin
		case (ex_sel)
			mul_op_pkg::sel_hi: sel_val = product[2*xw-1:xw];
			mul_op_pkg::sel_word: sel_val = {{(xw/2){product[xw/2-1]}}, product[xw/2-1:0]};
			default: sel_val = product[xw-1:0];
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			result <= '0;
		end else begin
			out_valid <= ex_valid && !flush;
			if (ex_valid) begin
				result <= sel_val;
			end
		end
	end

endmodule

// File: src/mul_unit.sv
module mul_unit (
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic                           mul_valid,
	input  logic                           flush,
	input  logic [2:0]                     funct3,
	input  logic                           is_word,
	input  logic [mul_arith_pkg::xlen-1:0] multiplicand,
	input  logic [mul_arith_pkg::xlen-1:0] multiplier,
	output logic                           out_valid,
	output logic [mul_arith_pkg::xlen-1:0] result
);

	logic                             dec_valid;
	mul_op_pkg::res_sel_t             dec_sel;
	logic [mul_arith_pkg::opnd_w-1:0] dec_a;
	logic [mul_arith_pkg::opnd_w-1:0] dec_b;

	logic                             ex_valid;
	mul_op_pkg::res_sel_t             ex_sel;
	logic [mul_arith_pkg::prod_w-1:0] ex_sum;
	logic [mul_arith_pkg::prod_w-1:0] ex_carry;

	mul_decode u_decode (
		.clk          (clk),
		.arst_n       (arst_n),
		.mul_valid    (mul_valid),
		.flush        (flush),
		.funct3       (funct3),
		.is_word      (is_word),
		.multiplicand (multiplicand),
		.multiplier   (multiplier),
		.dec_valid    (dec_valid),
		.dec_sel      (dec_sel),
		.dec_a        (dec_a),
		.dec_b        (dec_b)
	);

	mul_execute u_execute (
		.clk       (clk),
		.arst_n    (arst_n),
		.flush     (flush),
		.dec_valid (dec_valid),
		.dec_sel   (dec_sel),
		.dec_a     (dec_a),
		.dec_b     (dec_b),
		.ex_valid  (ex_valid),
		.ex_sel    (ex_sel),
		.ex_sum    (ex_sum),
		.ex_carry  (ex_carry)
	);

	mul_result u_result (
		.clk       (clk),
		.arst_n    (arst_n),
		.flush     (flush),
		.ex_valid  (ex_valid),
		.ex_sel    (ex_sel),
		.ex_sum    (ex_sum),
		.ex_carry  (ex_carry),
		.out_valid (out_valid),
		.result    (result)
	);

endmodule

// File: tests/mul_unit_assert.sv
module mul_unit_assert (
	input logic                           clk,
	input logic                           arst_n,
	input logic                           mul_valid,
	input logic                           flush,
	input logic                           out_valid,
	input logic [mul_arith_pkg::xlen-1:0] result
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// a flush empties the pipe, so nothing can reach the output for three cycles.
	flush_quiet: assert property (@(posedge clk) disable iff (!arst_n)
		flush |=> !out_valid [*3])
		else begin
			$error("out_valid rose within three cycles of a flush");
			fail_count++;
		end

	// every result traces back to a request three edges earlier.
	valid_origin: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid |-> $past(mul_valid, 3))
		else begin
			$error("out_valid without a request three cycles before");
			fail_count++;
		end

	result_known: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid |-> !$isunknown(result))
		else begin
			$error("result holds unknown bits while out_valid is high");
			fail_count++;
		end

endmodule

// File: tests/mul_unit_tb.sv
module mul_unit_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// about 450 operations of one to a few cycles each fit well within this limit.
	localparam int max_cycles = 20000;
	localparam logic [63:0] corners [6] = '{64'h0, 64'h1, 64'hffff_ffff_ffff_ffff,
		64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff, 64'hdead_beef_8000_0001};

	logic        clk = 1'b0;
	logic        arst_n;
	logic        mul_valid;
	logic        flush;
	logic        is_word;
	logic        out_valid;
	logic [2:0]  funct3;
	logic [63:0] multiplicand;
	logic [63:0] multiplier;
	logic [63:0] result;
	logic [31:0] lcg_state;
	logic [63:0] exp_q [$];
	int          cyc_q [$];
	int          cycles = 0;
	int          errors = 0;

	mul_unit dut0 (.*);

	bind mul_unit mul_unit_assert u_assert (.clk(clk), .arst_n(arst_n), .mul_valid(mul_valid),
		.flush(flush), .out_valid(out_valid), .result(result));

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout after %0d cycles, %0d results outstanding", cycles, exp_q.size());
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	function logic [63:0] rand64();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		rand64[63:32] = lcg_state;
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		rand64[31:0] = lcg_state;
	endfunction

	// MULH extends both operands with their sign, MULHSU only the multiplicand.
	function automatic logic [63:0] ref_result(input logic [2:0] f3, input logic w,
			input logic [63:0] a, input logic [63:0] b);
		logic [127:0] p;
		logic [63:0]  pw;
		p = {{64{a[63] & (f3 == 3'd1 || f3 == 3'd2)}}, a} * {{64{b[63] & (f3 == 3'd1)}}, b};
		pw = {32'd0, a[31:0]} * {32'd0, b[31:0]};
		if (w) begin
			return {{32{pw[31]}}, pw[31:0]};
		end
		return (f3 == 3'd0) ? p[63:0] : p[127:64];
	endfunction

	task automatic issue(input logic [2:0] f3, input logic w, input logic [63:0] a,
			input logic [63:0] b, input bit counted);
		@(negedge clk);
		mul_valid = 1'b1;
		flush = 1'b0;
		funct3 = f3;
		is_word = w;
		multiplicand = a;
		multiplier = b;
		if (counted) begin
			exp_q.push_back(ref_result(f3, w, a, b));
			cyc_q.push_back(cycles + 3);
		end
	endtask

	task automatic drain();
		@(negedge clk);
		mul_valid = 1'b0;
		flush = 1'b0;
		while (exp_q.size() != 0) @(negedge clk);
		repeat (4) @(negedge clk);
	endtask

	always @(negedge clk) begin
		logic [63:0] exp_val;
		int          exp_cyc;
		if (out_valid) begin
			assert (exp_q.size() != 0) else begin
				$display("out_valid rose at cycle %0d with no operation outstanding", cycles);
				errors++;
			end
			if (exp_q.size() != 0) begin
				exp_val = exp_q.pop_front();
				exp_cyc = cyc_q.pop_front();
				assert (result === exp_val) else begin
					$display("Mismatch result: expected %h, actual %h", exp_val, result);
					errors++;
				end
				assert (cycles == exp_cyc) else begin
					$display("result came at cycle %0d instead of cycle %0d", cycles, exp_cyc);
					errors++;
				end
			end
		end
	end

	task automatic check_products(input logic [2:0] f3, input logic w, input int n_rand);
		for (int i = 0; i < 36 + n_rand; i++) begin
			if (i < 36) begin
				issue(f3, w, corners[i/6], corners[i%6], 1'b1);
			end else begin
				issue(f3, w, rand64(), rand64(), 1'b1);
			end
		end
		drain();
	endtask

	task automatic back_to_back();
		logic [2:0] f3;
		for (int i = 0; i < 32; i++) begin
			f3 = 3'(i % 4);
			issue(f3, f3 == 3'd0 && i[2], rand64(), rand64(), 1'b1);
		end
		drain();
	endtask

	// the first operation completes just before the flush edge and the next three are cancelled.
	task automatic flush_in_flight();
		issue(mul_op_pkg::funct3_mulhu, 1'b0, rand64(), rand64(), 1'b1);
		for (int i = 0; i < 3; i++) begin
			issue(mul_op_pkg::funct3_mulh, 1'b0, rand64(), rand64(), 1'b0);
		end
		flush = 1'b1;
		issue(mul_op_pkg::funct3_mulhsu, 1'b0, rand64(), rand64(), 1'b1);
		drain();
	endtask

	task automatic reject_illegal();
		for (int i = 4; i < 11; i++) begin
			issue(3'(i < 8 ? i : i - 7), i >= 8 || i[0], rand64(), rand64(), 1'b0);
		end
		drain();
	endtask

	initial begin
		arst_n = 1'b0;
		mul_valid = 1'b0;
		flush = 1'b0;
		funct3 = 3'd0;
		is_word = 1'b0;
		multiplicand = '0;
		multiplier = '0;
		lcg_state = 32'h5274;
		repeat (16) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		drain();
		reject_illegal();
		check_products(mul_op_pkg::funct3_mul, 1'b0, 100);
		check_products(mul_op_pkg::funct3_mulh, 1'b0, 30);
		check_products(mul_op_pkg::funct3_mulhsu, 1'b0, 30);
		check_products(mul_op_pkg::funct3_mulhu, 1'b0, 30);
		check_products(mul_op_pkg::funct3_mul, 1'b1, 30);
		back_to_back();
		flush_in_flight();
		assert (exp_q.size() == 0) else begin
			$display("%0d expected results never arrived", exp_q.size());
			errors++;
		end
		$display("checks done after %0d cycles, errors: %0d, assertion failures: %0d",
			cycles, errors, dut0.u_assert.fail_count);
		if (errors == 0 && dut0.u_assert.fail_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: mul_unit.f
src/mul_arith_pkg.sv
src/mul_op_pkg.sv
src/mul_decode.sv
src/booth_pp_gen.sv
src/wallace_tree.sv
src/mul_execute.sv
src/mul_result.sv
src/mul_unit.sv
tests/mul_unit_assert.sv
tests/mul_unit_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = mul_unit_tb
FILELIST = mul_unit.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then exit 1; fi
	@grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
